// ==== verilog/displayPkg.sv ====
package displayPkg;

	// APB register map, byte addresses on a 4-bit paddr
	localparam int ApbAddrWidth = 4;
	localparam int ApbDataWidth = 32;
	localparam logic [ApbAddrWidth-1:0] AddrValue = 4'h0;	// Sign and magnitude
	localparam logic [ApbAddrWidth-1:0] AddrCtrl = 4'h4;	// Mode and display enable
	localparam logic [ApbAddrWidth-1:0] AddrDiv = 4'h8;	// Scan divider

	// Field widths
	localparam int MagWidth = 12;	// Magnitude, three hex nybbles
	localparam int DivWidth = 16;	// Cycles per digit minus one
	localparam int NybWidth = 4;	// One digit code
	localparam int GlyphWidth = 7;	// Segments a..g

	// Bit positions inside the value and control words
	localparam int SignBit = MagWidth;	// Sign sits just above the magnitude
	localparam int CtrlModeBit = 0;	// 0 hex, 1 decimal
	localparam int CtrlOnBit = 1;	// Display enable

	// Largest magnitude that fits in three decimal digits
	localparam int DecimalMax = 999;

	// Rendering opcode
	typedef enum logic {
		modeHex = 1'b0,
		modeDecimal = 1'b1
	} displayMode;

	// Scan state, one per digit position
	typedef enum logic [1:0] {
		posRight = 2'd0,
		posMidRight = 2'd1,
		posMidLeft = 2'd2,
		posLeft = 2'd3
	} digitPos;

	// Digit code put out on decimal overflow, paired with the dash flag
	localparam logic [NybWidth-1:0] CodeDash = 4'hA;

	// Active-low glyphs in abcdefg order
	localparam logic [GlyphWidth-1:0] GlyphMinus = 7'b1111110;	// Only g lit
	localparam logic [GlyphWidth-1:0] GlyphBlank = 7'b1111111;	// All dark

endpackage

// ==== verilog/apbRegs.sv ====
`timescale 1ns/1ns

module apbRegs import displayPkg::*; (
	input logic clk,
	input logic rst,

	// APB slave
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [ApbAddrWidth-1:0] paddr,
	input logic [ApbDataWidth-1:0] pwdata,
	output logic [ApbDataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,

	// Register contents out to the display logic
	output logic sign,
	output logic [MagWidth-1:0] mag,
	output displayMode mode,
	output logic dispOn,
	output logic [DivWidth-1:0] scanDiv
);

	logic access;	// Access phase of a transfer
	logic addrHit;	// One of the three registers is addressed
	logic wrEn;
	logic [ApbDataWidth-1:0] rdData;

	assign access = psel && penable;
	assign addrHit = (paddr == AddrValue) || (paddr == AddrCtrl) || (paddr == AddrDiv);
	assign wrEn = access && pwrite && addrHit;

	// No wait states
	assign pready = 1'b1;
	assign pslverr = access && !addrHit;	// Unmapped address, write is dropped

	// Register writes land on the edge that closes the access phase
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sign <= 1'b0;
			mag <= '0;
			mode <= modeHex;
			dispOn <= 1'b0;
			scanDiv <= '0;
		end else if (wrEn) begin
			case (paddr)
				AddrValue: begin
					sign <= pwdata[SignBit];
					mag <= pwdata[MagWidth-1:0];
				end
				AddrCtrl: begin
					mode <= displayMode'(pwdata[CtrlModeBit]);
					dispOn <= pwdata[CtrlOnBit];
				end
				AddrDiv: scanDiv <= pwdata[DivWidth-1:0];
				default: ;	// Filtered out by addrHit
			endcase
		end
	end

	// Read-back mux, reserved bits stay zero
	always_comb begin
		rdData = '0;
		case (paddr)
			AddrValue: begin
				rdData[SignBit] = sign;
				rdData[MagWidth-1:0] = mag;
			end
			AddrCtrl: begin
				rdData[CtrlModeBit] = mode;
				rdData[CtrlOnBit] = dispOn;
			end
			AddrDiv: rdData[DivWidth-1:0] = scanDiv;
			default: rdData = '0;
		endcase
	end

	// Only drive read data while a read is selected
	assign prdata = (psel && !pwrite) ? rdData : '0;

endmodule

// ==== verilog/scanTimer.sv ====
`timescale 1ns/1ns

module scanTimer import displayPkg::*; (
	input logic clk,
	input logic rst,
	input logic [DivWidth-1:0] scanDiv,	// Cycles per position minus one
	output digitPos pos,	// Current digit position
	output logic posStep	// High on the first cycle of each new position
);

	logic [DivWidth-1:0] count;
	logic [DivWidth-1:0] divLatched;	// Divider in force for this dwell
	logic wrap;

	assign wrap = (count == divLatched);

	// Dwell counter, position walks left to right and wraps to the sign
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count <= '0;
			divLatched <= '0;
			pos <= posLeft;	// Scan starts on the sign
			posStep <= 1'b0;
		end else begin
			posStep <= wrap;
			if (wrap) begin
				count <= '0;
				divLatched <= scanDiv;	// New divider only at a reload
				pos <= digitPos'(pos - 2'd1);	// posRight wraps back to posLeft
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

// ==== verilog/valueFormatter.sv ====
`timescale 1ns/1ns

module valueFormatter import displayPkg::*; (
	input logic clk,
	input logic rst,
	input logic sign,
	input logic [MagWidth-1:0] mag,
	input displayMode mode,
	output logic [NybWidth-1:0] digit0,	// Rightmost digit
	output logic [NybWidth-1:0] digit1,
	output logic [NybWidth-1:0] digit2,	// Leftmost numeric digit
	output logic dash,	// Decimal overflow, show dashes
	output logic negative	// Show a minus in the sign position
);

	// Double-dabble scratch, three BCD digits above the binary input
	logic [3*NybWidth+MagWidth-1:0] shiftReg;
	logic [3*NybWidth-1:0] bcd;
	logic overflow;

	logic [NybWidth-1:0] nextDigit0;
	logic [NybWidth-1:0] nextDigit1;
	logic [NybWidth-1:0] nextDigit2;
	logic nextDash;

	// Binary to BCD
	// Thousands are dropped, overflow is caught by the compare below
	always_comb begin
		shiftReg = '0;
		shiftReg[MagWidth-1:0] = mag;
		for (int i = 0; i < MagWidth; i++) begin
			for (int d = 0; d < 3; d++) begin
				// Add 3 to any digit of 5 or more before the shift
				if (shiftReg[MagWidth + d*NybWidth +: NybWidth] >= 4'd5)
					shiftReg[MagWidth + d*NybWidth +: NybWidth] =
						shiftReg[MagWidth + d*NybWidth +: NybWidth] + 4'd3;
			end
			shiftReg = shiftReg << 1;
		end
		bcd = shiftReg[MagWidth +: 3*NybWidth];
	end

	assign overflow = (mag > MagWidth'(DecimalMax));

	// Pick the digit codes for the current mode
	always_comb begin
		nextDash = 1'b0;
		if (mode == modeHex) begin
			// Nybbles pass straight through
			nextDigit0 = mag[NybWidth-1:0];
			nextDigit1 = mag[2*NybWidth-1:NybWidth];
			nextDigit2 = mag[3*NybWidth-1:2*NybWidth];
		end else if (overflow) begin
			nextDigit0 = CodeDash;
			nextDigit1 = CodeDash;
			nextDigit2 = CodeDash;
			nextDash = 1'b1;
		end else begin
			nextDigit0 = bcd[NybWidth-1:0];	// Units
			nextDigit1 = bcd[2*NybWidth-1:NybWidth];	// Tens
			nextDigit2 = bcd[3*NybWidth-1:2*NybWidth];	// Hundreds
		end
	end

	// Registered outputs, one cycle behind the register file
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			digit0 <= '0;
			digit1 <= '0;
			digit2 <= '0;
			dash <= 1'b0;
			negative <= 1'b0;
		end else begin
			digit0 <= nextDigit0;
			digit1 <= nextDigit1;
			digit2 <= nextDigit2;
			dash <= nextDash;
			negative <= sign && (mag != '0);	// Never a minus zero
		end
	end

endmodule

// ==== verilog/segmentDriver.sv ====
`timescale 1ns/1ns

module segmentDriver import displayPkg::*; (
	input logic clk,
	input logic rst,
	input digitPos pos,
	input logic dispOn,
	input logic [NybWidth-1:0] digit0,
	input logic [NybWidth-1:0] digit1,
	input logic [NybWidth-1:0] digit2,
	input logic dash,
	input logic negative,

	// Active-low segment lines
	output logic segA,
	output logic segB,
	output logic segC,
	output logic segD,
	output logic segE,
	output logic segF,
	output logic segG,

	// Active-low digit enables
	output logic digRight,
	output logic digMidRight,
	output logic digMidLeft,
	output logic digLeft
);

	logic [NybWidth-1:0] code;	// Digit code for this position
	logic [GlyphWidth-1:0] glyph;	// Active-low pattern, abcdefg
	logic [3:0] enN;	// {left, midLeft, midRight, right}, active low

	// Hex font, lit segments written as ones then inverted
	function automatic logic [GlyphWidth-1:0] hexGlyph(input logic [NybWidth-1:0] nyb);
		case (nyb)	//  abcdefg
			4'h0: return ~7'b1111110;
			4'h1: return ~7'b0110000;
			4'h2: return ~7'b1101101;
			4'h3: return ~7'b1111001;
			4'h4: return ~7'b0110011;
			4'h5: return ~7'b1011011;
			4'h6: return ~7'b1011111;
			4'h7: return ~7'b1110000;
			4'h8: return ~7'b1111111;
			4'h9: return ~7'b1111011;
			4'hA: return ~7'b1110111;
			4'hB: return ~7'b0011111;	// Lower case b
			4'hC: return ~7'b1001110;
			4'hD: return ~7'b0111101;	// Lower case d
			4'hE: return ~7'b1001111;
			default: return ~7'b1000111;	// F
		endcase
	endfunction

	// Position mux and glyph select
	always_comb begin
		code = digit0;
		enN = 4'b1111;
		case (pos)
			posRight: begin code = digit0; enN = 4'b1110; end
			posMidRight: begin code = digit1; enN = 4'b1101; end
			posMidLeft: begin code = digit2; enN = 4'b1011; end
			default: begin code = digit0; enN = 4'b0111; end	// posLeft, sign only
		endcase

		if (pos == posLeft)
			glyph = negative ? GlyphMinus : GlyphBlank;
		else if (dash)
			glyph = GlyphMinus;	// Decimal overflow
		else
			glyph = hexGlyph(code);

		// Display off, nothing lit and no digit driven
		if (!dispOn) begin
			enN = 4'b1111;
			glyph = GlyphBlank;
		end
	end

	// Output flops so the pins change together
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			{segA, segB, segC, segD, segE, segF, segG} <= GlyphBlank;
			{digLeft, digMidLeft, digMidRight, digRight} <= 4'b1111;
		end else begin
			{segA, segB, segC, segD, segE, segF, segG} <= glyph;
			{digLeft, digMidLeft, digMidRight, digRight} <= enN;
		end
	end

endmodule

// ==== verilog/displayTop.sv ====
`timescale 1ns/1ns

module displayTop import displayPkg::*; (
	input logic clk,
	input logic rst,

	// APB slave port
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [ApbAddrWidth-1:0] paddr,
	input logic [ApbDataWidth-1:0] pwdata,
	output logic [ApbDataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,

	// LED display, all active low
	output logic segA,
	output logic segB,
	output logic segC,
	output logic segD,
	output logic segE,
	output logic segF,
	output logic segG,
	output logic digRight,
	output logic digMidRight,
	output logic digMidLeft,
	output logic digLeft
);

	// Register file outputs
	logic sign;
	logic [MagWidth-1:0] mag;
	displayMode mode;
	logic dispOn;
	logic [DivWidth-1:0] scanDiv;

	// Scan state
	digitPos pos;

	// Formatted value
	logic [NybWidth-1:0] digit0;
	logic [NybWidth-1:0] digit1;
	logic [NybWidth-1:0] digit2;
	logic dash;
	logic negative;

	apbRegs apbRegs_inst (
		.clk, .rst,
		.psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.sign, .mag, .mode, .dispOn, .scanDiv
	);

	scanTimer scanTimer_inst (.clk, .rst, .scanDiv, .pos, .posStep());

	valueFormatter valueFormatter_inst (
		.clk, .rst, .sign, .mag, .mode,
		.digit0, .digit1, .digit2, .dash, .negative
	);

	segmentDriver segmentDriver_inst (
		.clk, .rst, .pos, .dispOn,
		.digit0, .digit1, .digit2, .dash, .negative,
		.segA, .segB, .segC, .segD, .segE, .segF, .segG,
		.digRight, .digMidRight, .digMidLeft, .digLeft
	);

endmodule

// ==== tests/displayTb.sv ====
`timescale 1ns/1ns

module displayTb import displayPkg::*; ();

	localparam int WaitLimit = 200;	// Cycles allowed for any single wait

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [ApbAddrWidth-1:0] paddr;
	logic [ApbDataWidth-1:0] pwdata;
	logic [ApbDataWidth-1:0] prdata;
	logic pready;
	logic pslverr;
	logic segA, segB, segC, segD, segE, segF, segG;
	logic digRight, digMidRight, digMidLeft, digLeft;

	logic [GlyphWidth-1:0] segs;
	logic [3:0] enables;	// {left, midLeft, midRight, right}
	int cycleCount = 0;

	assign segs = {segA, segB, segC, segD, segE, segF, segG};
	assign enables = {digLeft, digMidLeft, digMidRight, digRight};

	displayTop displayTop_inst (
		.clk, .rst,
		.psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.segA, .segB, .segC, .segD, .segE, .segF, .segG,
		.digRight, .digMidRight, .digMidLeft, .digLeft
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	always @(posedge clk) cycleCount <= cycleCount + 1;	// Time base for dwell checks

	task automatic compareVal(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (expected !== actual) begin
			$display("FAIL at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// Two-phase APB write, response sampled mid access phase
	task automatic apbWrite(input logic [ApbAddrWidth-1:0] addr, input logic [31:0] data,
			output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		err = pslverr;
		compareVal("pready", 32'(pready), 32'd1);
		@(posedge clk);	// Register updates on this edge
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apbRead(input logic [ApbAddrWidth-1:0] addr, output logic [31:0] data,
			output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		err = pslverr;
		compareVal("pready", 32'(pready), 32'd1);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// Write, then read back and check data and error flag
	task automatic writeAndReadBack(input logic [ApbAddrWidth-1:0] addr,
			input logic [31:0] data, input logic [31:0] expected);
		logic err;
		logic [31:0] rd;
		apbWrite(addr, data, err);
		compareVal("pslverr on write", 32'(err), 32'd0);
		apbRead(addr, rd, err);
		compareVal("pslverr on read", 32'(err), 32'd0);
		compareVal("prdata", rd, expected);
	endtask

	// Wait for a fresh falling edge of one digit enable, 0 right .. 3 left
	task automatic waitEnableFall(input int idx, output int cyc);
		int waited;
		waited = 0;
		while (enables[idx] == 1'b0) begin	// Leave a visit already in progress
			@(negedge clk);
			waited++;
			if (waited > WaitLimit) begin
				$display("Digit enable %0d never went inactive", idx);
				$display("tests failed");
				$fatal(1);
			end
		end
		while (enables[idx] == 1'b1) begin
			@(negedge clk);
			waited++;
			if (waited > WaitLimit) begin
				$display("Digit enable %0d never went active", idx);
				$display("tests failed");
				$fatal(1);
			end
		end
		cyc = cycleCount;
	endtask

	int fd;
	int n;
	int caseCount;
	int tNow;
	int tPrev;
	string line;
	logic err;
	logic [31:0] rd;
	logic [31:0] mode, en, sign, mag, div;
	logic [31:0] glLeft, glMidLeft, glMidRight, glRight;
	logic [31:0] expGlyph [4];	// Indexed like enables
	logic [31:0] ctrlWord;
	logic [31:0] valueWord;

	initial begin
		rst <= 1'b1;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= '0;
		pwdata <= '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		compareVal("enables after reset", 32'(enables), 32'hf);
		compareVal("segments after reset", 32'(segs), 32'h7f);

		// Register map, reserved bits read as zero
		writeAndReadBack(AddrValue, 32'hffff_eabc, 32'h0000_0abc);
		writeAndReadBack(AddrValue, 32'h0000_1abc, 32'h0000_1abc);
		writeAndReadBack(AddrCtrl, 32'hffff_fffc, 32'h0000_0000);
		writeAndReadBack(AddrCtrl, 32'hffff_ffff, 32'h0000_0003);
		writeAndReadBack(AddrDiv, 32'hffff_0003, 32'h0000_0003);
		apbWrite(4'hc, 32'h0000_0000, err);	// Unmapped, dropped
		compareVal("pslverr on bad write", 32'(err), 32'd1);
		apbRead(4'hc, rd, err);
		compareVal("pslverr on bad read", 32'(err), 32'd1);
		compareVal("prdata on bad read", rd, 32'd0);
		apbRead(AddrValue, rd, err);
		compareVal("value after bad write", rd, 32'h0000_1abc);
		apbRead(AddrCtrl, rd, err);
		compareVal("ctrl after bad write", rd, 32'h0000_0003);
		apbRead(AddrDiv, rd, err);
		compareVal("div after bad write", rd, 32'h0000_0003);

		fd = $fopen("tests/displayCases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the cases file");
			$display("tests failed");
			$fatal(1);
		end
		caseCount = 0;
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#") begin	// Skip column notes
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", mode, en, sign, mag, div,
					glLeft, glMidLeft, glMidRight, glRight);
				if (n == 9) begin
					caseCount++;
					expGlyph[3] = glLeft;
					expGlyph[2] = glMidLeft;
					expGlyph[1] = glMidRight;
					expGlyph[0] = glRight;
					ctrlWord = '0;
					ctrlWord[CtrlModeBit] = mode[0];
					ctrlWord[CtrlOnBit] = en[0];
					valueWord = '0;
					valueWord[SignBit] = sign[0];
					valueWord[MagWidth-1:0] = mag[MagWidth-1:0];
					apbWrite(AddrDiv, div, err);
					apbWrite(AddrCtrl, ctrlWord, err);
					apbWrite(AddrValue, valueWord, err);
					repeat (3) @(negedge clk);	// Register to pin latency

					if (en[0]) begin
						// One scan left to right, glyph and dwell at each position
						for (int idx = 3; idx >= 0; idx--) begin
							waitEnableFall(idx, tNow);
							compareVal($sformatf("segments at position %0d", idx),
								32'(segs), expGlyph[idx]);
							compareVal("active enables", 32'($countones(~enables)), 32'd1);
							if (idx < 3)
								compareVal("dwell cycles", tNow - tPrev, div + 1);
							tPrev = tNow;
						end
					end else begin
						// Blank for a whole scan period
						for (int c = 0; c < 4 * (div + 1) + 4; c++) begin
							@(negedge clk);
							compareVal("enables while off", 32'(enables), 32'hf);
							compareVal("segments while off", 32'(segs), 32'h7f);
						end
					end
				end
			end
		end
		$fclose(fd);

		if (caseCount == 0) begin
			$display("The cases file held no cases");
			$display("tests failed");
			$fatal(1);
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

// ==== tests/displayCases.txt ====
# mode enable sign mag div glyphLeft glyphMidLeft glyphMidRight glyphRight
# All fields hex, glyphs active low in abcdefg order
0 1 1 abc 3 7e 08 60 31
0 1 0 123 0 7f 4f 12 06
0 1 0 def 5 7f 42 30 38
0 1 1 000 2 7f 01 01 01
0 1 1 890 1 7e 00 04 01
1 1 1 315 4 7e 0f 00 04
1 1 0 07b 1 7f 4f 12 06
1 1 1 000 2 7f 01 01 01
1 1 0 3e7 0 7f 04 04 04
1 1 1 3e8 3 7e 7e 7e 7e
1 1 0 fff 2 7f 7e 7e 7e
0 0 0 456 3 7f 7f 7f 7f
0 1 0 456 3 7f 4c 24 20
1 1 0 045 6 7f 01 20 04
1 0 1 100 2 7f 7f 7f 7f
1 1 1 100 1 7e 12 24 20
0 1 0 7a5 2 7f 0f 08 24

// ==== compile.f ====
verilog/displayPkg.sv
verilog/apbRegs.sv
verilog/scanTimer.sv
verilog/valueFormatter.sv
verilog/segmentDriver.sv
verilog/displayTop.sv
tests/displayTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the display testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	--top-module displayTb \
	-f compile.f \
	-o displaySim

./obj_dir/displaySim
